// ==== src/lcdPkg.sv ====
package lcdPkg;

	// screens shown on the front panel
	typedef enum logic [3:0]
	{
		pressKey,
		selectMaster,
		selectSlave,
		inputAddress,
		inputData,
		inputBursts,
		saveConfig,
		switchNormal,
		normalMode
	} screenT;

	// HD44780 command bytes used by the writer
	typedef enum logic [7:0]
	{
		functionSet  = 8'h38, // 8-bit bus, two lines, 5x8 font
		displayOn    = 8'h0C, // display on, cursor off
		clearDisplay = 8'h01,
		entryMode    = 8'h06, // increment, no shift
		line1Addr    = 8'h80, // DDRAM address 00h
		line2Addr    = 8'hC0  // DDRAM address 40h
	} lcdCmdT;

	typedef logic [7:0] charT;

	localparam int charsPerLine = 16;

	// element charsPerLine-1 is the leftmost character on the panel,
	// so a 16 character string literal maps straight onto a line
	typedef charT [charsPerLine-1:0] lineT;

	typedef struct packed
	{
		lineT line1;
		lineT line2;
	} displayT;

	typedef struct packed
	{
		logic en;
		logic rs;   // 1 character, 0 command
		charT data;
	} lcdBusT;

	localparam charT asciiZero  = 8'h30;
	localparam charT asciiOne   = 8'h31;
	localparam charT asciiSpace = 8'h20;

	// configuration step that stores the configuration
	localparam logic [3:0] saveStep = 4'd6;

endpackage

// ==== src/screenDecode.sv ====
`timescale 1ns/1ps

module screenDecode (
	input  logic           clock,
	input  logic           rst,
	input  logic [3:0]     configState,
	input  logic           modeSwitch,
	output lcdPkg::screenT screen
);
	import lcdPkg::*;

	logic   savedFlag; // configuration stored since last normal mode
	screenT nextScreen;

	always_ff @(posedge clock)
	begin
		if (!rst)
			savedFlag <= 1'b0;
		else if (modeSwitch)
			savedFlag <= 1'b0; // leaving config mode forgets the save
		else if (configState == saveStep)
			savedFlag <= 1'b1;
	end

	always_comb
	begin
		if (modeSwitch)
			nextScreen = normalMode;
		else
		begin
			case (configState)
				4'd0:     nextScreen = savedFlag ? switchNormal : pressKey;
				4'd1:     nextScreen = selectMaster;
				4'd2:     nextScreen = selectSlave;
				4'd3:     nextScreen = inputAddress;
				4'd4:     nextScreen = inputData;
				4'd5:     nextScreen = inputBursts;
				saveStep: nextScreen = saveConfig;
				default:  nextScreen = pressKey; // unused steps
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst)
			screen <= pressKey;
		else
			screen <= nextScreen;
	end

	// the composer has no entry for codes past normalMode
	screenLegal: assert property (@(posedge clock) disable iff (!rst)
		screen inside {[pressKey:normalMode]});

endmodule

// ==== src/lineComposer.sv ====
`timescale 1ns/1ps

module lineComposer #(
	parameter int dataWidth = 14
) (
	input  logic                 clock,
	input  logic                 rst,
	input  lcdPkg::screenT       screen,
	input  logic [dataWidth-1:0] dataLine1,
	input  logic [dataWidth-1:0] dataLine2,
	output lcdPkg::displayT      display
);
	import lcdPkg::*;

	localparam lineT blankLine = {charsPerLine{asciiSpace}};

	displayT nextDisplay;

	// left-justify a short string literal and fill the rest with spaces;
	// the literal arrives right-aligned with zero bytes in front
	function automatic lineT padLine(input lineT text);
		lineT result;
		int   len;
		len = 0;
		for (int i = 0; i < charsPerLine; i++)
		begin
			if (text[i] != 8'h00)
				len = i + 1;
		end
		result = blankLine;
		for (int k = 0; k < charsPerLine; k++)
		begin
			if (k < len)
				result[charsPerLine-1-k] = text[len-1-k];
		end
		return result;
	endfunction

	// tag, dash, then the bits msb first as '0'/'1'
	function automatic lineT formatBits(input charT tag, input logic [dataWidth-1:0] bits);
		lineT result;
		result = blankLine;
		result[charsPerLine-1] = tag;
		result[charsPerLine-2] = "-";
		for (int i = 0; i < dataWidth; i++)
			result[charsPerLine-3-i] = bits[dataWidth-1-i] ? asciiOne : asciiZero;
		return result;
	endfunction

	always_comb
	begin
		nextDisplay.line2 = blankLine; // most screens use only line 1
		case (screen)
			pressKey:
				nextDisplay.line1 = padLine("Press Any Key");
			selectMaster:
				nextDisplay.line1 = padLine("Select Master");
			selectSlave:
				nextDisplay.line1 = padLine("Select Slave");
			inputAddress:
			begin
				nextDisplay.line1 = padLine("Input Address");
				nextDisplay.line2 = padLine("SW[0:11]");
			end
			inputData:
			begin
				nextDisplay.line1 = padLine("Input Data");
				nextDisplay.line2 = padLine("SW[0:7]");
			end
			inputBursts:
			begin
				nextDisplay.line1 = padLine("Input Number of");
				nextDisplay.line2 = padLine("Bursts");
			end
			saveConfig:
				nextDisplay.line1 = padLine("Save Config");
			switchNormal:
			begin
				nextDisplay.line1 = padLine("Switch to Normal");
				nextDisplay.line2 = padLine("Mode");
			end
			normalMode:
			begin
				nextDisplay.line1 = formatBits("A", dataLine1); // address word
				nextDisplay.line2 = formatBits("D", dataLine2); // data word
			end
			default:
				nextDisplay.line1 = blankLine;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			display.line1 <= blankLine;
			display.line2 <= blankLine;
		end
		else
			display <= nextDisplay;
	end

endmodule

// ==== src/lcdStrobe.sv ====
`timescale 1ns/1ps

module lcdStrobe #(
	parameter int enPulseCycles = 2
) (
	input  logic          clock,
	input  logic          rst,
	input  logic          send,
	input  lcdPkg::lcdBusT byteOut,
	output logic          busy,
	output lcdPkg::lcdBusT bus
);
	import lcdPkg::*;

	localparam int cntWidth = $clog2(enPulseCycles + 1);

	typedef enum logic [1:0] {idle, setup, pulse, hold} strobeStateT;

	strobeStateT          state;
	logic [cntWidth-1:0]  pulseCount;
	lcdBusT               held; // byte on the pins for the whole transfer

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			state      <= idle;
			pulseCount <= '0;
			held       <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (send)
					begin
						held  <= byteOut;
						state <= setup;
					end
				end
				setup:
				begin
					pulseCount <= '0;
					state      <= pulse;
				end
				pulse:
				begin
					if (int'(pulseCount) == enPulseCycles - 1)
						state <= hold;
					else
						pulseCount <= pulseCount + 1'b1;
				end
				hold:
					state <= idle; // panel latches on the falling edge
				default:
					state <= idle;
			endcase
		end
	end

	assign busy     = (state != idle);
	assign bus.en   = (state == pulse);
	assign bus.rs   = held.rs;
	assign bus.data = held.data;

	// the writer must wait for the previous byte to finish
	sendWhenIdle: assert property (@(posedge clock) disable iff (!rst)
		send |-> !busy);

	busStableInPulse: assert property (@(posedge clock) disable iff (!rst)
		bus.en && $past(bus.en) |-> $stable({bus.rs, bus.data}));

endmodule

// ==== src/lcdWriter.sv ====
`timescale 1ns/1ps

module lcdWriter #(
	parameter int initWaitCycles = 40,
	parameter int enPulseCycles  = 2
) (
	input  logic            clock,
	input  logic            rst,
	input  lcdPkg::displayT display,
	output lcdPkg::lcdBusT  bus
);
	import lcdPkg::*;

	localparam int frameLen  = 2 * charsPerLine + 2; // two address commands plus text
	localparam int line2Pos  = charsPerLine + 1;
	localparam int posWidth  = $clog2(frameLen);
	localparam int idxWidth  = $clog2(charsPerLine);
	localparam int waitWidth = $clog2(initWaitCycles + 1);

	typedef enum logic [1:0] {powerWait, initSeq, refresh} writerStateT;

	writerStateT          state;
	logic [waitWidth-1:0] waitCount;
	logic [1:0]           initIndex;
	logic [posWidth-1:0]  framePos;
	logic [idxWidth-1:0]  charIdx;
	displayT              snapshot; // frozen copy for the current frame
	lcdBusT               byteOut;
	logic                 send;
	logic                 busy;

	assign send = (state != powerWait) && !busy;

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			state     <= powerWait;
			waitCount <= '0;
			initIndex <= '0;
			framePos  <= '0;
		end
		else
		begin
			case (state)
				powerWait:
				begin
					if (int'(waitCount) == initWaitCycles - 1)
						state <= initSeq;
					else
						waitCount <= waitCount + 1'b1;
				end
				initSeq:
				begin
					if (send)
					begin
						if (initIndex == 2'd3)
							state <= refresh;
						initIndex <= initIndex + 1'b1;
					end
				end
				refresh:
				begin
					if (send)
					begin
						if (framePos == frameLen - 1)
							framePos <= '0;
						else
							framePos <= framePos + 1'b1;
					end
				end
				default:
					state <= powerWait;
			endcase
		end
	end

	// snapshot taken as line1Addr goes out
	always_ff @(posedge clock)
	begin
		if (state == refresh && send && framePos == 0)
			snapshot <= display;
	end

	always_comb
	begin
		byteOut = '0; // en is generated by the strobe
		charIdx = '0;
		if (state == initSeq)
		begin
			case (initIndex)
				2'd0:    byteOut.data = functionSet;
				2'd1:    byteOut.data = displayOn;
				2'd2:    byteOut.data = clearDisplay;
				default: byteOut.data = entryMode;
			endcase
		end
		else if (framePos == 0)
			byteOut.data = line1Addr;
		else if (framePos == line2Pos)
			byteOut.data = line2Addr;
		else if (framePos < line2Pos)
		begin
			charIdx      = idxWidth'(charsPerLine - int'(framePos)); // leftmost first
			byteOut.rs   = 1'b1;
			byteOut.data = snapshot.line1[charIdx];
		end
		else
		begin
			charIdx      = idxWidth'(frameLen - 1 - int'(framePos));
			byteOut.rs   = 1'b1;
			byteOut.data = snapshot.line2[charIdx];
		end
	end

	lcdStrobe #(
		.enPulseCycles(enPulseCycles)
	) strobe (
		.clock  (clock),
		.rst    (rst),
		.send   (send),
		.byteOut(byteOut),
		.busy   (busy),
		.bus    (bus)
	);

	// panel must see no enable before its supply has settled
	quietPowerUp: assert property (@(posedge clock) disable iff (!rst)
		state == powerWait |-> !bus.en);

endmodule

// ==== src/lcdText.sv ====
`timescale 1ns/1ps

module lcdText #(
	parameter int dataWidth      = 14,
	parameter int initWaitCycles = 40,
	parameter int enPulseCycles  = 2
) (
	input  logic                 clock,
	input  logic                 rst,
	input  logic [dataWidth-1:0] dataLine1,
	input  logic [dataWidth-1:0] dataLine2,
	input  logic [3:0]           configState,
	input  logic                 modeSwitch,
	output logic                 lcdOn,   // panel power
	output logic                 lcdBlon, // backlight
	output logic                 lcdRw,   // 0 write, reads unused
	output logic                 lcdEn,
	output logic                 lcdRs,   // 0 command, 1 character
	output logic [7:0]           lcdData
);
	import lcdPkg::*;

	screenT  screen;
	displayT display;
	lcdBusT  bus;

	screenDecode decode (
		.clock      (clock),
		.rst        (rst),
		.configState(configState),
		.modeSwitch (modeSwitch),
		.screen     (screen)
	);

	lineComposer #(
		.dataWidth(dataWidth)
	) composer (
		.clock    (clock),
		.rst      (rst),
		.screen   (screen),
		.dataLine1(dataLine1),
		.dataLine2(dataLine2),
		.display  (display)
	);

	lcdWriter #(
		.initWaitCycles(initWaitCycles),
		.enPulseCycles (enPulseCycles)
	) writer (
		.clock  (clock),
		.rst    (rst),
		.display(display),
		.bus    (bus)
	);

	assign lcdOn   = 1'b1;
	assign lcdBlon = 1'b1;
	assign lcdRw   = 1'b0; // write only, busy flag never polled
	assign lcdEn   = bus.en;
	assign lcdRs   = bus.rs;
	assign lcdData = bus.data;

endmodule

// ==== sim/screenModel.svh ====
`ifndef SCREEN_MODEL_SVH
`define SCREEN_MODEL_SVH

localparam int lineChars = 16;

typedef logic [8*lineChars-1:0] textT; // leftmost character in the top byte

logic modelSaved = 1'b0; // config stored since last normal mode

// text left-justified, rest of the line spaces
function automatic textT textLine(input string text);
	textT line;
	line = {lineChars{8'h20}};
	for (int k = 0; k < lineChars && k < text.len(); k++)
		line[8*lineChars-1-8*k -: 8] = text[k];
	return line;
endfunction

// tag, dash, then bits msb first
function automatic textT bitsLine(input logic [7:0] tag, input logic [dataWidth-1:0] bits);
	textT line;
	line = {lineChars{8'h20}};
	line[8*lineChars-1 -: 8] = tag;
	line[8*lineChars-9 -: 8] = "-";
	for (int i = 0; i < dataWidth; i++)
		line[8*lineChars-17-8*i -: 8] = bits[dataWidth-1-i] ? "1" : "0";
	return line;
endfunction

// advances the saved flag, then looks up both lines
task automatic expectLines(input logic [3:0] cfg, input logic mode,
	input logic [dataWidth-1:0] d1, input logic [dataWidth-1:0] d2,
	output textT line1, output textT line2);
	if (mode)
		modelSaved = 1'b0;
	else if (cfg == 4'd6)
		modelSaved = 1'b1;
	line2 = textLine("");
	if (mode)
	begin
		line1 = bitsLine("A", d1);
		line2 = bitsLine("D", d2);
	end
	else
	begin
		case (cfg)
			4'd0: line1 = textLine(modelSaved ? "Switch to Normal" : "Press Any Key");
			4'd1: line1 = textLine("Select Master");
			4'd2: line1 = textLine("Select Slave");
			4'd3: line1 = textLine("Input Address");
			4'd4: line1 = textLine("Input Data");
			4'd5: line1 = textLine("Input Number of");
			4'd6: line1 = textLine("Save Config");
			default: line1 = textLine("Press Any Key"); // steps 7 to 15
		endcase
		if (cfg == 4'd3)
			line2 = textLine("SW[0:11]");
		else if (cfg == 4'd4)
			line2 = textLine("SW[0:7]");
		else if (cfg == 4'd5)
			line2 = textLine("Bursts");
		else if (cfg == 4'd0 && modelSaved)
			line2 = textLine("Mode");
	end
endtask

`endif

// ==== sim/lcdTextTb.sv ====
`timescale 1ns/1ps

module lcdTextTb;

	localparam int dataWidth      = 14;
	localparam int initWaitCycles = 40;
	localparam int enPulseCycles  = 2;
	localparam int frameBytes     = 34;
	localparam int numTests       = 21;
	localparam int timeoutCycles  =
		(initWaitCycles + (numTests * 3 + 2) * frameBytes * (enPulseCycles + 2)) * 2;

	`include "screenModel.svh"

	logic                 clock;
	logic                 rst;
	logic [dataWidth-1:0] dataLine1;
	logic [dataWidth-1:0] dataLine2;
	logic [3:0]           configState;
	logic                 modeSwitch;
	logic                 lcdOn;
	logic                 lcdBlon;
	logic                 lcdRw;
	logic                 lcdEn;
	logic                 lcdRs;
	logic [7:0]           lcdData;

	int   errorCount = 0;
	int   cycleCount = 0;
	int   sinceReset = 0;
	int   byteCount  = 0; // bytes seen on the panel bus
	int   framesDone = 0;
	textT rxLine1;        // frame being received
	textT rxLine2;
	textT lastLine1;      // last complete frame
	textT lastLine2;

	lcdText #(
		.dataWidth     (dataWidth),
		.initWaitCycles(initWaitCycles),
		.enPulseCycles (enPulseCycles)
	) uut (
		.clock      (clock),
		.rst        (rst),
		.dataLine1  (dataLine1),
		.dataLine2  (dataLine2),
		.configState(configState),
		.modeSwitch (modeSwitch),
		.lcdOn      (lcdOn),
		.lcdBlon    (lcdBlon),
		.lcdRw      (lcdRw),
		.lcdEn      (lcdEn),
		.lcdRs      (lcdRs),
		.lcdData    (lcdData)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic checkEq(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		if (expected !== actual)
		begin
			errorCount++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [7:0] initCmd(input int idx);
		case (idx)
			0:       return 8'h38; // 8-bit bus, two lines
			1:       return 8'h0C;
			2:       return 8'h01;
			default: return 8'h06;
		endcase
	endfunction

	// static levels, and no enable during reset and power-on wait
	always @(negedge clock)
	begin
		checkEq("power pins", 3'b110, {lcdOn, lcdBlon, lcdRw});
		if (!rst || sinceReset < initWaitCycles)
			checkEq("reset enable", 1'b0, lcdEn);
		sinceReset = rst ? sinceReset + 1 : 0;
	end

	// panel latches each byte on the falling enable edge
	always @(negedge lcdEn)
	begin : busMonitor
		int pos;
		if (rst === 1'b1)
		begin
			if (byteCount < 4)
				checkEq("init command", {1'b0, initCmd(byteCount)}, {lcdRs, lcdData});
			else
			begin
				pos = (byteCount - 4) % frameBytes;
				if (pos == 0)
					checkEq("frame line1 address", 9'h080, {lcdRs, lcdData});
				else if (pos == lineChars + 1)
					checkEq("frame line2 address", 9'h0C0, {lcdRs, lcdData});
				else
				begin
					checkEq("frame character rs", 1'b1, lcdRs);
					if (pos <= lineChars)
						rxLine1[8*lineChars-1-8*(pos-1) -: 8] = lcdData;
					else
						rxLine2[8*lineChars-1-8*(pos-lineChars-2) -: 8] = lcdData;
				end
				if (pos == frameBytes - 1)
				begin
					lastLine1 = rxLine1;
					lastLine2 = rxLine2;
					framesDone++;
				end
			end
			byteCount++;
		end
	end

	// hold the inputs for three frames, then check the newest one
	task automatic runStep(input string name, input logic [3:0] cfg, input logic mode);
		textT        expLine1;
		textT        expLine2;
		logic [31:0] r1;
		logic [31:0] r2;
		int          mark;
		r1 = $urandom;
		r2 = $urandom;
		@(posedge clock);
		configState <= cfg;
		modeSwitch  <= mode;
		dataLine1   <= r1[dataWidth-1:0];
		dataLine2   <= r2[dataWidth-1:0];
		expectLines(cfg, mode, r1[dataWidth-1:0], r2[dataWidth-1:0], expLine1, expLine2);
		@(negedge clock);
		mark = framesDone;
		wait (framesDone >= mark + 3);
		checkEq(name, {expLine1, expLine2}, {lastLine1, lastLine2});
	endtask

	initial
	begin
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: panel frames stopped arriving after %0d cycles", cycleCount);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin : stimulus
		logic [31:0] r;
		void'($urandom(63));
		rst         = 1'b0;
		configState = 4'd0;
		modeSwitch  = 1'b0;
		dataLine1   = '0;
		dataLine2   = '0;
		repeat (5) @(posedge clock);
		rst <= 1'b1;
		runStep("pressKey after reset", 4'd0, 1'b0);
		repeat (6)
		begin
			r = $urandom_range(6, 1);
			runStep("config step", r[3:0], 1'b0);
		end
		repeat (4)
		begin
			r = $urandom_range(15, 7);
			runStep("unused step", r[3:0], 1'b0); // falls back to pressKey
		end
		repeat (6)
			runStep("normal mode", 4'd0, 1'b1);
		runStep("save step", 4'd6, 1'b0);
		runStep("step 0 after save", 4'd0, 1'b0);
		runStep("normal after save", 4'd0, 1'b1);
		runStep("step 0 after normal", 4'd0, 1'b0); // saved flag forgotten
		$display("Checks done with %0d errors", errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+sim
src/lcdPkg.sv
src/screenDecode.sv
src/lineComposer.sv
src/lcdStrobe.sv
src/lcdWriter.sv
src/lcdText.sv
sim/lcdTextTb.sv

// ==== Bender.yml ====
package:
  name: lcdtext

sources:
  - files:
      - src/lcdPkg.sv
      - src/screenDecode.sv
      - src/lineComposer.sv
      - src/lcdStrobe.sv
      - src/lcdWriter.sv
      - src/lcdText.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/lcdTextTb.sv
